// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  // major opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_ALUI   = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_ALU    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    CU_IDLE      = 3'd0,
    CU_FETCH_REQ = 3'd1,
    CU_FETCH_REL = 3'd2,
    CU_DECODE    = 3'd3,
    CU_EXEC      = 3'd4,
    CU_MEM_REQ   = 3'd5,
    CU_MEM_REL   = 3'd6,
    CU_WRITEBACK = 3'd7
  } cu_state_t;

  // ALU_EQ and ALU_SLT leave a single result bit in bit 0
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SRL    = 4'd5,
    ALU_OR     = 4'd6,
    ALU_AND    = 4'd7,
    ALU_EQ     = 4'd8,
    ALU_PASS_B = 4'd9
  } alu_op_t;

  typedef enum logic {
    ALU_A_REG = 1'b0,
    ALU_A_PC  = 1'b1
  } alu_in_a_t;

  typedef enum logic {
    ALU_B_REG = 1'b0,
    ALU_B_IMM = 1'b1
  } alu_in_b_t;

  // writeback source for rd
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_ALU  = 2'd1,
    DEST_MEM  = 2'd2,
    DEST_PC4  = 2'd3
  } dest_from_t;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_kind_t;

endpackage

// ==== src/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               halt,
  input  logic               mem_ack,
  input  rv_pkg::opcode_t    opcode,
  input  logic [2:0]         funct3,
  input  logic [6:0]         funct7,
  input  logic               branch_taken,
  output logic               mem_req,
  output logic               mem_we,
  output logic               addr_sel_pc,
  output logic               ir_load,
  output logic               mdr_load,
  output rv_pkg::alu_in_a_t  alu_a_sel,
  output rv_pkg::alu_in_b_t  alu_b_sel,
  output rv_pkg::alu_op_t    alu_op,
  output logic               alu_signed,
  output logic               cmp_invert,
  output rv_pkg::imm_kind_t  imm_kind,
  output rv_pkg::dest_from_t dest_sel,
  output logic               rd_we,
  output logic               pc_step,
  output logic               pc_load
);

  // where the alu mode comes from
  typedef enum logic [1:0] {
    MODE_ADD,
    MODE_ARITH,
    MODE_BRANCH,
    MODE_PASS
  } mode_from_t;

  typedef struct packed {
    rv_pkg::alu_in_a_t  alu_a;
    rv_pkg::alu_in_b_t  alu_b;
    mode_from_t         mode;
    rv_pkg::dest_from_t dest;
    rv_pkg::imm_kind_t  imm;
    logic               mem;
    logic               jump;
  } dp_map_t;

  localparam dp_map_t map_none = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_REG, MODE_ADD,
                                   rv_pkg::DEST_NONE, rv_pkg::IMM_I, 1'b0, 1'b0};
  localparam dp_map_t map_alu = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_REG, MODE_ARITH,
                                  rv_pkg::DEST_ALU, rv_pkg::IMM_I, 1'b0, 1'b0};
  localparam dp_map_t map_alui = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_IMM, MODE_ARITH,
                                   rv_pkg::DEST_ALU, rv_pkg::IMM_I, 1'b0, 1'b0};
  localparam dp_map_t map_load = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_IMM, MODE_ADD,
                                   rv_pkg::DEST_MEM, rv_pkg::IMM_I, 1'b1, 1'b0};
  localparam dp_map_t map_store = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_IMM, MODE_ADD,
                                    rv_pkg::DEST_NONE, rv_pkg::IMM_S, 1'b1, 1'b0};
  localparam dp_map_t map_branch = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_REG, MODE_BRANCH,
                                     rv_pkg::DEST_NONE, rv_pkg::IMM_B, 1'b0, 1'b0};
  localparam dp_map_t map_jal = '{rv_pkg::ALU_A_PC, rv_pkg::ALU_B_IMM, MODE_ADD,
                                  rv_pkg::DEST_PC4, rv_pkg::IMM_J, 1'b0, 1'b1};
  localparam dp_map_t map_jalr = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_IMM, MODE_ADD,
                                   rv_pkg::DEST_PC4, rv_pkg::IMM_I, 1'b0, 1'b1};
  localparam dp_map_t map_lui = '{rv_pkg::ALU_A_REG, rv_pkg::ALU_B_IMM, MODE_PASS,
                                  rv_pkg::DEST_ALU, rv_pkg::IMM_U, 1'b0, 1'b0};
  localparam dp_map_t map_auipc = '{rv_pkg::ALU_A_PC, rv_pkg::ALU_B_IMM, MODE_ADD,
                                    rv_pkg::DEST_ALU, rv_pkg::IMM_U, 1'b0, 1'b0};

  rv_pkg::cu_state_t state;
  rv_pkg::cu_state_t state_next;
  dp_map_t           dp;
  logic              handshake;
  logic              redirect;

  assign handshake = mem_req && mem_ack;

  always_comb begin
    state_next = state;
    case (state)
      rv_pkg::CU_IDLE: begin
        if (!halt) state_next = rv_pkg::CU_FETCH_REQ;
      end
      rv_pkg::CU_FETCH_REQ: begin
        if (handshake) state_next = rv_pkg::CU_FETCH_REL;
      end
      rv_pkg::CU_FETCH_REL: begin
        if (!mem_ack) state_next = rv_pkg::CU_DECODE;
      end
      rv_pkg::CU_DECODE: state_next = rv_pkg::CU_EXEC;
      rv_pkg::CU_EXEC: begin
        state_next = dp.mem ? rv_pkg::CU_MEM_REQ : rv_pkg::CU_WRITEBACK;
      end
      rv_pkg::CU_MEM_REQ: begin
        if (handshake) state_next = rv_pkg::CU_MEM_REL;
      end
      rv_pkg::CU_MEM_REL: begin
        if (!mem_ack) state_next = rv_pkg::CU_WRITEBACK;
      end
      default: state_next = halt ? rv_pkg::CU_IDLE : rv_pkg::CU_FETCH_REQ;
    endcase
  end

  // request goes up together with entry into a request state
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state   <= rv_pkg::CU_IDLE;
      mem_req <= 1'b0;
    end else begin
      state   <= state_next;
      mem_req <= (state_next == rv_pkg::CU_FETCH_REQ) || (state_next == rv_pkg::CU_MEM_REQ);
    end
  end

  always_comb begin
    case (opcode)
      rv_pkg::OP_ALU:    dp = map_alu;
      rv_pkg::OP_ALUI:   dp = map_alui;
      rv_pkg::OP_LOAD:   dp = map_load;
      rv_pkg::OP_STORE:  dp = map_store;
      rv_pkg::OP_BRANCH: dp = map_branch;
      rv_pkg::OP_JAL:    dp = map_jal;
      rv_pkg::OP_JALR:   dp = map_jalr;
      rv_pkg::OP_LUI:    dp = map_lui;
      rv_pkg::OP_AUIPC:  dp = map_auipc;
      // unknown opcodes fall through as a no-op
      default:           dp = map_none;
    endcase
  end

  always_comb begin
    alu_op     = rv_pkg::ALU_ADD;
    alu_signed = 1'b0;
    cmp_invert = 1'b0;
    case (dp.mode)
      MODE_ARITH: begin
        case (funct3)
          3'd0: begin
            if (opcode == rv_pkg::OP_ALU && funct7 == 7'b0100000) alu_op = rv_pkg::ALU_SUB;
          end
          3'd1: alu_op = rv_pkg::ALU_SLL;
          3'd2: begin
            alu_op     = rv_pkg::ALU_SLT;
            alu_signed = 1'b1;
          end
          3'd3: alu_op = rv_pkg::ALU_SLT;
          3'd4: alu_op = rv_pkg::ALU_XOR;
          3'd5: begin
            alu_op     = rv_pkg::ALU_SRL;
            alu_signed = funct7[5];
          end
          3'd6: alu_op = rv_pkg::ALU_OR;
          default: alu_op = rv_pkg::ALU_AND;
        endcase
      end
      MODE_BRANCH: begin
        // bit 2 picks less-than over equal and bit 1 marks an unsigned compare
        if (funct3[2]) alu_op = rv_pkg::ALU_SLT;
        else alu_op = rv_pkg::ALU_EQ;
        alu_signed = !funct3[1];
        cmp_invert = funct3[0];
      end
      MODE_PASS: alu_op = rv_pkg::ALU_PASS_B;
      default: alu_op = rv_pkg::ALU_ADD;
    endcase
  end

  assign alu_a_sel = dp.alu_a;
  assign alu_b_sel = dp.alu_b;
  assign imm_kind  = dp.imm;
  assign dest_sel  = dp.dest;

  assign addr_sel_pc = !((state == rv_pkg::CU_MEM_REQ) || (state == rv_pkg::CU_MEM_REL));
  assign mem_we      = (state == rv_pkg::CU_MEM_REQ) && (opcode == rv_pkg::OP_STORE);
  assign ir_load     = (state == rv_pkg::CU_FETCH_REQ) && handshake;
  assign mdr_load    = (state == rv_pkg::CU_MEM_REQ) && handshake;

  assign redirect = dp.jump || ((opcode == rv_pkg::OP_BRANCH) && branch_taken);
  assign rd_we    = (state == rv_pkg::CU_WRITEBACK) && (dp.dest != rv_pkg::DEST_NONE);
  assign pc_load  = (state == rv_pkg::CU_WRITEBACK) && redirect;
  assign pc_step  = (state == rv_pkg::CU_WRITEBACK) && !redirect;

endmodule

// ==== src/program_counter.sv ====
`timescale 1ns/1ps

module program_counter #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pc_step,
  input  logic                    pc_load,
  input  logic [rv_pkg::xlen-1:0] target,
  output logic [rv_pkg::xlen-1:0] pc
);

  logic [rv_pkg::xlen-1:0] pc_next;

  // a jump target always lands on an even address
  always_comb begin
    pc_next = pc;
    if (pc_load) begin
      pc_next = {target[rv_pkg::xlen-1:1], 1'b0};
    end else if (pc_step) begin
      pc_next = pc + rv_pkg::xlen'(4);
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [4:0]              rd_addr,
  input  logic                    rd_we,
  input  logic [rv_pkg::xlen-1:0] rd_data,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  input  logic                    addr_sel_pc,
  input  logic                    ir_load,
  input  logic                    mdr_load,
  input  rv_pkg::alu_in_a_t       alu_a_sel,
  input  rv_pkg::alu_in_b_t       alu_b_sel,
  input  rv_pkg::alu_op_t         alu_op,
  input  logic                    alu_signed,
  input  logic                    cmp_invert,
  input  rv_pkg::imm_kind_t       imm_kind,
  input  rv_pkg::dest_from_t      dest_sel,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::opcode_t         opcode,
  output logic [2:0]              funct3,
  output logic [6:0]              funct7,
  output logic                    branch_taken,
  output logic [4:0]              rs1_addr,
  output logic [4:0]              rs2_addr,
  output logic [4:0]              rd_addr,
  output logic [rv_pkg::xlen-1:0] rd_data,
  output logic [rv_pkg::xlen-1:0] target,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata
);

  logic [rv_pkg::xlen-1:0] ir;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] alu_y;
  logic [rv_pkg::xlen-1:0] alu_q;
  logic [rv_pkg::xlen-1:0] mdr;
  logic [rv_pkg::xlen-1:0] wdata_q;
  logic [4:0]              shamt;
  logic                    less;

  assign opcode   = rv_pkg::opcode_t'(ir[6:0]);
  assign rd_addr  = ir[11:7];
  assign funct3   = ir[14:12];
  assign rs1_addr = ir[19:15];
  assign rs2_addr = ir[24:20];
  assign funct7   = ir[31:25];

  always_comb begin
    case (imm_kind)
      rv_pkg::IMM_S: imm = {{(rv_pkg::xlen-12){ir[31]}}, ir[31:25], ir[11:7]};
      rv_pkg::IMM_B: imm = {{(rv_pkg::xlen-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      rv_pkg::IMM_U: imm = {ir[31:12], 12'b0};
      rv_pkg::IMM_J: imm = {{(rv_pkg::xlen-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      default:       imm = {{(rv_pkg::xlen-12){ir[31]}}, ir[31:20]};
    endcase
  end

  assign op_a  = (alu_a_sel == rv_pkg::ALU_A_PC) ? pc : rs1_data;
  assign op_b  = (alu_b_sel == rv_pkg::ALU_B_IMM) ? imm : rs2_data;
  assign shamt = op_b[4:0];
  assign less  = alu_signed ? ($signed(op_a) < $signed(op_b)) : (op_a < op_b);

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_y = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_y = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_y = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_y = {{(rv_pkg::xlen-1){1'b0}}, less};
      rv_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
      rv_pkg::ALU_SRL: begin
        if (alu_signed) alu_y = $signed(op_a) >>> shamt;
        else alu_y = op_a >> shamt;
      end
      rv_pkg::ALU_OR:     alu_y = op_a | op_b;
      rv_pkg::ALU_AND:    alu_y = op_a & op_b;
      rv_pkg::ALU_EQ:     alu_y = {{(rv_pkg::xlen-1){1'b0}}, op_a == op_b};
      rv_pkg::ALU_PASS_B: alu_y = op_b;
      default:            alu_y = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ir           <= '0;
      branch_taken <= 1'b0;
    end else begin
      if (ir_load) ir <= mem_rdata;
      branch_taken <= alu_y[0] ^ cmp_invert;
    end
  end

  // operands hold still from decode to writeback, so these settle by the end of exec
  always_ff @(posedge clk) begin
    alu_q   <= alu_y;
    wdata_q <= rs2_data;
    if (mdr_load) mdr <= mem_rdata;
  end

  assign target = (opcode == rv_pkg::OP_BRANCH) ? pc + imm : alu_q;

  always_comb begin
    case (dest_sel)
      rv_pkg::DEST_ALU: rd_data = alu_q;
      rv_pkg::DEST_MEM: rd_data = mdr;
      rv_pkg::DEST_PC4: rd_data = pc + rv_pkg::xlen'(4);
      default:          rd_data = '0;
    endcase
  end

  // fetch drives the pc and a quiet data bus
  assign mem_addr  = addr_sel_pc ? pc : alu_q;
  assign mem_wdata = addr_sel_pc ? '0 : wdata_q;

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    halt,
  output logic                    mem_req,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic                    mem_we,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  input  logic                    mem_ack,
  input  logic [rv_pkg::xlen-1:0] mem_rdata
);

  rv_pkg::opcode_t         opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic                    branch_taken;
  logic                    addr_sel_pc;
  logic                    ir_load;
  logic                    mdr_load;
  rv_pkg::alu_in_a_t       alu_a_sel;
  rv_pkg::alu_in_b_t       alu_b_sel;
  rv_pkg::alu_op_t         alu_op;
  logic                    alu_signed;
  logic                    cmp_invert;
  rv_pkg::imm_kind_t       imm_kind;
  rv_pkg::dest_from_t      dest_sel;
  logic                    rd_we;
  logic                    pc_step;
  logic                    pc_load;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] target;
  logic [4:0]              rs1_addr;
  logic [4:0]              rs2_addr;
  logic [4:0]              rd_addr;
  logic [rv_pkg::xlen-1:0] rd_data;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;

  control_unit i_control_unit (
    .clk          (clk),
    .rst          (rst),
    .halt         (halt),
    .mem_ack      (mem_ack),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .branch_taken (branch_taken),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .addr_sel_pc  (addr_sel_pc),
    .ir_load      (ir_load),
    .mdr_load     (mdr_load),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_op       (alu_op),
    .alu_signed   (alu_signed),
    .cmp_invert   (cmp_invert),
    .imm_kind     (imm_kind),
    .dest_sel     (dest_sel),
    .rd_we        (rd_we),
    .pc_step      (pc_step),
    .pc_load      (pc_load)
  );

  program_counter #(
    .reset_pc (reset_pc)
  ) i_program_counter (
    .clk     (clk),
    .rst     (rst),
    .pc_step (pc_step),
    .pc_load (pc_load),
    .target  (target),
    .pc      (pc)
  );

  register_file i_register_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit i_exec_unit (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .mem_rdata    (mem_rdata),
    .addr_sel_pc  (addr_sel_pc),
    .ir_load      (ir_load),
    .mdr_load     (mdr_load),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_op       (alu_op),
    .alu_signed   (alu_signed),
    .cmp_invert   (cmp_invert),
    .imm_kind     (imm_kind),
    .dest_sel     (dest_sel),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .branch_taken (branch_taken),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .target       (target),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata)
  );

endmodule

// ==== testbench/rv_core_checker.sv ====
`timescale 1ns/1ps

module rv_core_checker (
  input logic                    clk,
  input logic                    rst,
  input logic                    mem_req,
  input logic                    mem_ack,
  input logic                    mem_we,
  input logic [rv_pkg::xlen-1:0] mem_addr,
  input logic [rv_pkg::xlen-1:0] mem_wdata,
  input rv_pkg::cu_state_t       state
);

  // read by the testbench at the end of the run
  int assert_fails = 0;

  req_held: assert property (@(posedge clk) disable iff (!rst)
      mem_req && !mem_ack |=> mem_req)
    else begin
      $error("mem_req fell before mem_ack rose");
      assert_fails++;
    end

  // address, direction and write data hold until the ack
  req_stable: assert property (@(posedge clk) disable iff (!rst)
      mem_req && !mem_ack |=> $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
    else begin
      $error("request fields changed while waiting for mem_ack");
      assert_fails++;
    end

  no_early_req: assert property (@(posedge clk) disable iff (!rst)
      $rose(mem_req) |-> !$past(mem_ack))
    else begin
      $error("mem_req rose while mem_ack was still high");
      assert_fails++;
    end

  state_legal: assert property (@(posedge clk) disable iff (!rst)
      !$isunknown(state) && (state inside {rv_pkg::CU_IDLE, rv_pkg::CU_FETCH_REQ,
      rv_pkg::CU_FETCH_REL, rv_pkg::CU_DECODE, rv_pkg::CU_EXEC, rv_pkg::CU_MEM_REQ,
      rv_pkg::CU_MEM_REL, rv_pkg::CU_WRITEBACK}))
    else begin
      $error("control state left the legal set");
      assert_fails++;
    end

endmodule

bind rv_core rv_core_checker i_rv_core_checker (
  .clk       (clk),
  .rst       (rst),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .mem_we    (mem_we),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .state     (i_control_unit.state)
);

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] reset_pc  = 32'h0000_0200;
  localparam logic [31:0] data_base = 32'h0000_0c00;
  localparam logic [31:0] self_loop = 32'h0000_006f;

  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_alui   = 7'b0010011;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_alu    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_jal    = 7'b1101111;

  logic        clk = 1'b0;
  logic        rst;
  logic        halt;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  logic [31:0] mem [1024];
  logic [31:0] ref_mem [1024];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] lcg_state = 32'ha1a9efaa;
  logic [31:0] end_fetch_pc = '1;
  int          n_st;
  int          n_stores;
  int          end_hits;
  int          err_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          budget_cycles = 100;

  rv_core #(
    .reset_pc (reset_pc)
  ) i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .halt      (halt),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // four-phase memory, random wait before each ack edge
  always begin : memory_model
    logic [31:0] r;
    @(negedge clk);
    if (rst && mem_req && !mem_ack) begin
      r = lcg_next();
      repeat (r[17:16]) @(negedge clk);
      if (mem_we) begin
        mem[mem_addr[11:2]] = mem_wdata;
      end else begin
        mem_rdata = mem[mem_addr[11:2]];
      end
      mem_ack = 1'b1;
      @(negedge clk);
      while (mem_req) @(negedge clk);
      r = lcg_next();
      repeat (r[17:16]) @(negedge clk);
      mem_ack = 1'b0;
    end
  end

  always @(posedge clk) begin : compare_stores
    logic [31:0] ea;
    logic [31:0] ed;
    if (rst && mem_req && mem_ack && mem_we) begin
      if (exp_addr.size() == 0) begin
        $display("extra store at %0t: %h written to %h when no store was expected",
                 $time, mem_wdata, mem_addr);
        err_count++;
      end else begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        if (mem_addr !== ea || mem_wdata !== ed) begin
          $display("** Error at %0t: store %h to %h, expected %h to %h",
                   $time, mem_wdata, mem_addr, ed, ea);
          err_count++;
        end
        n_stores++;
      end
    end
    if (rst && mem_req && mem_ack && !mem_we && mem_addr == end_fetch_pc) begin
      end_hits++;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles, the core stopped making progress", cycles);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] y;
    case (f3)
      3'd0: y = alt ? a - b : a + b;
      3'd1: y = a << b[4:0];
      3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: y = (a < b) ? 32'd1 : 32'd0;
      3'd4: y = a ^ b;
      3'd5: begin
        if (alt) y = $signed(a) >>> b[4:0];
        else y = a >> b[4:0];
      end
      3'd6: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  // ISA model over ref_mem, fills the expected store queues
  function automatic int run_reference(input logic [31:0] start_pc);
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        take;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = start_pc;
    steps = 0;
    ins = ref_mem[pc[11:2]];
    while (ins != self_loop && steps < 4000) begin
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      rd = ins[11:7];
      f3 = ins[14:12];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      next_pc = pc + 32'd4;
      case (ins[6:0])
        op_alu: x[rd] = alu_ref(f3, ins[30], a, b);
        op_alui: x[rd] = alu_ref(f3, ins[30] && (f3 == 3'd5), a, imm_i);
        op_load: begin
          ea = a + imm_i;
          x[rd] = ref_mem[ea[11:2]];
        end
        op_store: begin
          ea = a + imm_s;
          ref_mem[ea[11:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        op_branch: begin
          case (f3)
            3'd0: take = (a == b);
            3'd1: take = (a != b);
            3'd4: take = ($signed(a) < $signed(b));
            3'd5: take = ($signed(a) >= $signed(b));
            3'd6: take = (a < b);
            default: take = (a >= b);
          endcase
          if (take) next_pc = pc + imm_b;
        end
        op_jal: begin
          x[rd] = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        op_jalr: begin
          next_pc = (a + imm_i) & ~32'd1;
          x[rd] = pc + 32'd4;
        end
        op_lui: x[rd] = {ins[31:12], 12'b0};
        op_auipc: x[rd] = pc + {ins[31:12], 12'b0};
        default: ;
      endcase
      x[0] = '0;
      pc = next_pc;
      steps++;
      ins = ref_mem[pc[11:2]];
    end
    return steps;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_alu};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sw_word(input logic [11:0] off, input logic [4:0] rs2);
    return {off[11:5], rs2, 5'd10, 3'd2, off[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    prog.push_back({hi[31:12], rd, op_lui});
    prog.push_back(i_type(v[11:0], rd, 3'd0, rd, op_alui));
  endtask

  task automatic store_reg(input logic [4:0] rs);
    prog.push_back(sw_word(12'(n_st * 4), rs));
    n_st++;
  endtask

  // x10 holds the data base in every program
  task automatic begin_program();
    prog.delete();
    n_st = 0;
    load_imm(5'd10, data_base);
  endtask

  task automatic build_alu();
    logic [31:0] r;
    begin_program();
    repeat (3) begin
      load_imm(5'd1, lcg_next());
      load_imm(5'd2, lcg_next());
      for (int f = 0; f < 8; f++) begin
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
        store_reg(5'd3);
        if (f == 0 || f == 5) begin
          prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'(f), 5'd3));
          store_reg(5'd3);
        end
        r = lcg_next();
        if (f == 1 || f == 5) begin
          prog.push_back(i_type({7'h00, r[24:20]}, 5'd1, 3'(f), 5'd4, op_alui));
          store_reg(5'd4);
          if (f == 5) begin
            prog.push_back(i_type({7'h20, r[28:24]}, 5'd1, 3'(f), 5'd4, op_alui));
            store_reg(5'd4);
          end
        end else begin
          prog.push_back(i_type(r[31:20], 5'd1, 3'(f), 5'd4, op_alui));
          store_reg(5'd4);
        end
      end
    end
    prog.push_back(self_loop);
  endtask

  task automatic build_mem();
    begin_program();
    // first read sees the fill pattern
    prog.push_back(i_type(12'd1020, 5'd10, 3'd2, 5'd8, op_load));
    store_reg(5'd8);
    repeat (4) begin
      load_imm(5'd1, lcg_next());
      store_reg(5'd1);
      prog.push_back(i_type(12'((n_st - 1) * 4), 5'd10, 3'd2, 5'd5, op_load));
      prog.push_back(i_type(12'h5a3, 5'd5, 3'd0, 5'd5, op_alui));
      store_reg(5'd5);
      prog.push_back(i_type(12'((n_st - 1) * 4), 5'd10, 3'd2, 5'd6, op_load));
      prog.push_back(r_type(7'h00, 5'd1, 5'd6, 3'd4, 5'd7));
      store_reg(5'd7);
    end
    prog.push_back(self_loop);
  endtask

  task automatic build_branch();
    logic [31:0] a [4];
    logic [31:0] b [4];
    logic [2:0]  conds [6];
    logic [31:0] r;
    int          mark;
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    a[0] = lcg_next();
    b[0] = a[0];
    a[1] = lcg_next() | 32'h8000_0000;
    b[1] = lcg_next() & 32'h7fff_ffff;
    a[2] = b[1];
    b[2] = a[1];
    r = lcg_next();
    a[3] = r | 32'h8000_0000;
    b[3] = r & 32'h0000_00ff;
    begin_program();
    mark = 1;
    for (int p = 0; p < 4; p++) begin
      load_imm(5'd1, a[p]);
      load_imm(5'd2, b[p]);
      // not-taken path then taken path, both store to one slot
      for (int c = 0; c < 6; c++) begin
        prog.push_back(b_type(13'd16, 5'd2, 5'd1, conds[c]));
        prog.push_back(i_type(12'(mark), 5'd0, 3'd0, 5'd3, op_alui));
        prog.push_back(sw_word(12'(n_st * 4), 5'd3));
        prog.push_back(j_type(21'd12, 5'd0));
        prog.push_back(i_type(12'(mark + 1), 5'd0, 3'd0, 5'd3, op_alui));
        store_reg(5'd3);
        mark += 2;
      end
    end
    prog.push_back(self_loop);
  endtask

  task automatic build_jump();
    logic [31:0] r;
    begin_program();
    r = lcg_next();
    prog.push_back({r[31:12], 5'd1, op_lui});
    store_reg(5'd1);
    r = lcg_next();
    prog.push_back({r[31:12], 5'd2, op_auipc});
    store_reg(5'd2);
    prog.push_back(j_type(21'd8, 5'd3));
    prog.push_back(i_type(12'h155, 5'd0, 3'd0, 5'd5, op_alui));
    store_reg(5'd3);
    store_reg(5'd5);
    // odd jalr offset, bit 0 of the target is dropped
    prog.push_back({20'h0, 5'd6, op_auipc});
    prog.push_back(i_type(12'd17, 5'd6, 3'd0, 5'd7, op_jalr));
    prog.push_back(i_type(12'h2aa, 5'd0, 3'd0, 5'd5, op_alui));
    prog.push_back(i_type(12'h3bb, 5'd0, 3'd0, 5'd5, op_alui));
    store_reg(5'd7);
    store_reg(5'd5);
    prog.push_back(self_loop);
  endtask

  task automatic build_halt();
    begin_program();
    repeat (8) begin
      load_imm(5'd1, lcg_next());
      store_reg(5'd1);
      prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd2));
      store_reg(5'd2);
    end
    prog.push_back(self_loop);
  endtask

  task automatic build_undef();
    begin_program();
    load_imm(5'd1, lcg_next());
    store_reg(5'd1);
    prog.push_back(32'h1234_50ff);
    store_reg(5'd1);
    // custom-0 opcode naming x1 as rd
    prog.push_back(32'h0000_108b);
    store_reg(5'd1);
    prog.push_back(self_loop);
  endtask

  task automatic run_program(input string name, input int halt_after);
    int steps;
    int errs_at_start;
    errs_at_start = err_count;
    @(negedge clk);
    halt = 1'b1;
    rst  = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h9e37_79b9 * 32'(i + 1);
    end
    foreach (prog[i]) mem[reset_pc[11:2] + i] = prog[i];
    ref_mem = mem;
    exp_addr.delete();
    exp_data.delete();
    steps = run_reference(reset_pc);
    budget_cycles += steps * 30 + 300;
    end_fetch_pc = reset_pc + 32'(4 * (prog.size() - 1));
    n_stores = 0;
    end_hits = 0;
    repeat (10) @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    halt = 1'b0;
    if (halt_after > 0) begin
      while (n_stores < halt_after) @(negedge clk);
      halt = 1'b1;
      repeat (40) begin
        if (mem_req) begin
          $display("memory request seen at %0t while the core is halted", $time);
          err_count++;
        end
        @(negedge clk);
      end
      halt = 1'b0;
    end
    while (end_hits == 0) @(negedge clk);
    halt = 1'b1;
    repeat (20) @(negedge clk);
    if (exp_addr.size() != 0) begin
      $display("%0d expected stores never reached the memory bus", exp_addr.size());
      err_count++;
    end
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok, %0d stores checked over %0d instructions", name, n_stores, steps);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_count - errs_at_start);
    end
  endtask

  initial begin : main
    rst       = 1'b0;
    halt      = 1'b1;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    build_alu();
    run_program("alu", 0);
    build_mem();
    run_program("load_store", 0);
    build_branch();
    run_program("branch", 0);
    build_jump();
    run_program("jump_upper", 0);
    build_halt();
    run_program("halt", 5);
    build_undef();
    run_program("undefined_opcode", 0);
    $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_passed, tests_failed, err_count,
             i_rv_core.i_rv_core_checker.assert_fails);
    if (err_count == 0 && tests_failed == 0 &&
        i_rv_core.i_rv_core_checker.assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/rv_pkg.sv
src/control_unit.sv
src/program_counter.sv
src/register_file.sv
src/exec_unit.sv
src/rv_core.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv
